// File: list.f
logic/mips_types_pkg.sv
logic/except_pkg.sv
logic/commit_stage_reg.sv
logic/slot_exc_classify.sv
logic/exception_ctrl.sv
logic/cp0_regs.sv
logic/exc_unit_top.sv
testbench/exc_unit_checker.sv
testbench/exc_unit_monitor.sv
testbench/exc_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module exc_unit_tb -f list.f -o exc_unit_sim

status=0
./obj_dir/exc_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "Simulation passed (exit status $status)"
    exit 0
fi
echo "Simulation failed (exit status $status), see sim.log"
exit 1

// File: testbench/exc_unit_tb.sv
`default_nettype none

module exc_unit_tb;

    import mips_types_pkg::*;
    import except_pkg::*;

    localparam int N_SLOTS     = 2;
    localparam int N_TESTS     = 6;
    localparam int TEST_LEN    = 400;                        // Cycles per test
    localparam int CYCLE_LIMIT = N_TESTS * TEST_LEN + 100;

    logic                       clk;
    logic                       rst;
    commit_slot_t [N_SLOTS-1:0] commit_in;
    logic [N_INT-1:0]           int_lines;
    cp0_sel_t                   rd_sel;
    logic                       redirect_valid;
    addr_t                      redirect_pc;
    logic                       flush;
    addr_t                      rd_data;
    logic [7:0]                 test_id;
    logic                       test_done;
    int                         err_total;
    int                         fail_tests;
    int                         errors;
    int                         seed;
    int                         cycle = 0;

    exc_unit_top #(.N_SLOTS(N_SLOTS)) i_dut (
        .clk            (clk),
        .rst            (rst),
        .commit_in      (commit_in),
        .int_lines      (int_lines),
        .rd_sel         (rd_sel),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .rd_data        (rd_data)
    );

    exc_unit_monitor #(.N_SLOTS(N_SLOTS)) u_monitor (
        .clk            (clk),
        .rst            (rst),
        .commit_in      (commit_in),
        .int_lines      (int_lines),
        .rd_sel         (rd_sel),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .rd_data        (rd_data),
        .test_id        (test_id),
        .test_done      (test_done),
        .err_total      (err_total),
        .fail_tests     (fail_tests)
    );

    bind exc_unit_top exc_unit_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .flush          (flush),
        .upd_ena        (cp0_upd.update_ena),
        .rd_sel         (rd_sel),
        .rd_data        (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic chance(int pct);
        return pick(100) < pct;
    endfunction

    function automatic logic [7:0] rand_flags(int pct);
        logic [7:0] f;
        for (int b = 0; b < 8; b++) begin
            f[b] = chance(pct);
        end
        return f;
    endfunction

    // Flag mix per test, bits are eret syscall brk inst_adel data_adel data_ades ov ri
    function automatic exc_flags_t gen_flags(int test, int idx);
        exc_flags_t f;
        case (test)
            1:       f = (idx == 0 && chance(50)) ? exc_flags_t'(8'h01 << pick(8)) : '0;
            2:       f = rand_flags(30);
            3:       f = exc_flags_t'(rand_flags(30) & 8'h1c);   // Address faults only
            4:       f = exc_flags_t'(rand_flags(25) & 8'hc0);   // Eret and syscall
            5:       f = exc_flags_t'(rand_flags(15) & 8'h80);
            default: f = rand_flags(50);                         // Back to back flushes
        endcase
        return f;
    endfunction

    function automatic cp0_sel_t rand_sel();
        case (pick(4))
            0:       return CP0_BADVADDR;
            1:       return CP0_STATUS;
            2:       return CP0_CAUSE;
            default: return CP0_EPC;
        endcase
    endfunction

    task automatic drive_cycle(input int test);
        commit_slot_t [N_SLOTS-1:0] bundle;
        logic [N_INT-1:0]           lines;
        for (int i = 0; i < N_SLOTS; i++) begin
            bundle[i].valid         = (test == 1 && i == 0) || chance(70);
            bundle[i].pc            = $random(seed);
            bundle[i].in_delay_slot = chance(test == 3 ? 50 : 20);
            bundle[i].data_addr     = $random(seed);
            bundle[i].flags         = gen_flags(test, i);
        end
        lines = '0;
        if (chance(test == 5 ? 8 : 2)) begin
            lines = N_INT'(1 << pick(N_INT));   // One cycle pulse
        end
        commit_in <= bundle;
        int_lines <= lines;
        rd_sel    <= rand_sel();
    endtask

    initial begin
        seed      = 32'he558;
        rst       = 1'b1;
        commit_in = '0;
        int_lines = '0;
        rd_sel    = CP0_STATUS;
        test_id   = '0;
        test_done = 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            drive_cycle(N_TESTS);   // Reset has to discard busy traffic
        end
        rst <= 1'b0;
        for (int t = 1; t <= N_TESTS; t++) begin
            for (int c = 0; c < TEST_LEN; c++) begin
                @(posedge clk);
                test_id   <= 8'(t);
                test_done <= (c == TEST_LEN - 1);
                drive_cycle(t);
            end
        end
        @(posedge clk);
        test_done <= 1'b0;
        commit_in <= '0;
        @(posedge clk);
        errors = err_total + i_dut.u_checker.violations;
        $display("Tests run %0d, tests failed %0d, errors %0d", N_TESTS, fail_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/exc_unit_monitor.sv
`default_nettype none

module exc_unit_monitor #(
    parameter int N_SLOTS = 2
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire  except_pkg::commit_slot_t [N_SLOTS-1:0] commit_in,
    input  wire  [mips_types_pkg::N_INT-1:0]             int_lines,
    input  wire  mips_types_pkg::cp0_sel_t               rd_sel,
    input  wire                                          redirect_valid,
    input  wire  mips_types_pkg::addr_t                  redirect_pc,
    input  wire                                          flush,
    input  wire  mips_types_pkg::addr_t                  rd_data,
    input  wire  [7:0]                                   test_id,
    input  wire                                          test_done,
    output int                                           err_total,
    output int                                           fail_tests
);

    import mips_types_pkg::*;
    import except_pkg::*;

    localparam logic [1:0] K_NONE = 2'd0;   // No BadVAddr write
    localparam logic [1:0] K_PC   = 2'd1;
    localparam logic [1:0] K_DATA = 2'd2;
    localparam logic [1:0] K_ERET = 2'd3;

    commit_slot_t [N_SLOTS-1:0] m_stage;   // Model of the registered bundle
    logic [N_INT-1:0]           m_int_q;
    logic                       m_exl;
    logic                       m_bd;
    exccode_t                   m_code;
    addr_t                      m_epc;
    addr_t                      m_bva;
    logic                       ready = 1'b0;
    logic                       e_redir;
    logic                       e_eret;
    logic                       e_bd;
    logic                       e_bva_ena;
    logic                       found;
    exccode_t                   e_code;
    addr_t                      e_pc;
    addr_t                      e_epc;
    addr_t                      e_bva;
    addr_t                      exp_rd;
    logic [6:0]                 cause_r;
    int                         test_err = 0;
    int                         n_cycles = 0;
    int                         n_redir = 0;

    initial begin
        err_total  = 0;
        fail_tests = 0;
    end

    // Priority inst AdEL, RI, OV, SYS, BP, ERET, data AdEL, data AdES
    function automatic logic [6:0] rank_cause(exc_flags_t f);
        if (f.inst_adel) return {K_PC, EXC_ADEL};
        else if (f.ri) return {K_NONE, EXC_RI};
        else if (f.overflow) return {K_NONE, EXC_OV};
        else if (f.syscall) return {K_NONE, EXC_SYS};
        else if (f.brk) return {K_NONE, EXC_BP};
        else if (f.eret) return {K_ERET, EXC_INT};
        else if (f.data_adel) return {K_DATA, EXC_ADEL};
        else return {K_DATA, EXC_ADES};
    endfunction

    function automatic addr_t epc_of(commit_slot_t s);
        return s.in_delay_slot ? s.pc - 32'd4 : s.pc;
    endfunction

    always_comb begin
        {e_redir, e_eret, e_bd, e_bva_ena, found} = '0;
        {e_code, e_pc, e_epc, e_bva, cause_r} = '0;
        if (!m_exl && |m_int_q && m_stage[0].valid) begin    // IE=1 and IM all ones
            e_redir = 1'b1;
            e_pc    = EXC_VECTOR;
            e_code  = EXC_INT;
            e_bd    = m_stage[0].in_delay_slot;
            e_epc   = epc_of(m_stage[0]);
        end else begin
            for (int i = 0; i < N_SLOTS; i++) begin
                if (!found && m_stage[i].valid && |m_stage[i].flags) begin
                    found     = 1'b1;
                    cause_r   = rank_cause(m_stage[i].flags);
                    e_redir   = 1'b1;
                    e_eret    = cause_r[6:5] == K_ERET;
                    e_pc      = e_eret ? m_epc : EXC_VECTOR;
                    e_code    = cause_r[4:0];
                    e_bd      = m_stage[i].in_delay_slot;
                    e_epc     = epc_of(m_stage[i]);
                    e_bva_ena = cause_r[6:5] == K_PC || cause_r[6:5] == K_DATA;
                    e_bva     = cause_r[6:5] == K_PC ? m_stage[i].pc : m_stage[i].data_addr;
                end
            end
        end
    end

    always_comb begin
        case (rd_sel)
            CP0_BADVADDR: exp_rd = m_bva;
            CP0_STATUS:   exp_rd = 32'h0040_ff01 | {30'd0, m_exl, 1'b0};  // BEV, IM, IE
            CP0_CAUSE:    exp_rd = {m_bd, 15'd0, m_int_q, 2'b00, 1'b0, m_code, 2'b00};
            CP0_EPC:      exp_rd = m_epc;
            default:      exp_rd = '0;
        endcase
    end

    always @(posedge clk) begin
        if (rst) begin
            ready   <= 1'b1;
            m_stage <= '0;
            m_int_q <= '0;
            m_exl   <= 1'b1;
            m_bd    <= 1'b0;
            m_code  <= '0;
            m_epc   <= '0;
            m_bva   <= '0;
        end else begin
            m_stage <= e_redir ? '0 : commit_in;   // Flush drops the arriving bundle
            m_int_q <= int_lines;
            if (e_redir && !e_eret) begin
                m_exl  <= 1'b1;
                m_bd   <= e_bd;
                m_code <= e_code;
                m_epc  <= e_epc;
                if (e_bva_ena) begin
                    m_bva <= e_bva;
                end
            end else if (e_eret) begin
                m_exl <= 1'b0;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            test_err++;
            err_total++;
        end
    endtask

    always @(negedge clk) begin
        if (ready && !rst) begin
            compare("redirect_valid", 32'(redirect_valid), 32'(e_redir));
            compare("flush", 32'(flush), 32'(e_redir));
            if (e_redir) begin
                compare("redirect_pc", redirect_pc, e_pc);
                n_redir++;
            end
            compare("rd_data", rd_data, exp_rd);
            n_cycles++;
        end
        if (test_done) begin
            if (n_redir == 0) begin
                $display("Test %0d never caused a redirect, so nothing was exercised", test_id);
                test_err++;
                err_total++;
            end
            $display("Test %0d %s: %0d cycles, %0d redirects, %0d errors", test_id,
                     (test_err == 0) ? "ok" : "failed", n_cycles, n_redir, test_err);
            if (test_err != 0) begin
                fail_tests++;
            end
            test_err = 0;
            n_cycles = 0;
            n_redir  = 0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/exc_unit_checker.sv
`default_nettype none

module exc_unit_checker (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           redirect_valid,
    input  wire                           flush,
    input  wire                           upd_ena,
    input  wire mips_types_pkg::cp0_sel_t rd_sel,
    input  wire mips_types_pkg::addr_t    rd_data
);

    import mips_types_pkg::*;

    localparam int STATUS_EXL = 1;

    logic armed = 1'b0;     // High once the first edge has loaded known state
    int   violations = 0;

    always @(posedge clk) begin
        armed <= 1'b1;
    end

    a_flush_tracks_redirect: assert property (@(posedge clk) disable iff (!armed)
        redirect_valid == flush)
    else begin
        $error("flush differs from redirect_valid");
        violations++;
    end

    a_quiet_in_reset: assert property (@(posedge clk) (armed && rst) |-> !redirect_valid)
    else begin
        $error("redirect_valid raised while rst is high");
        violations++;
    end

    // An exception entry leaves Status.EXL set for the following cycle
    a_exl_after_entry: assert property (@(posedge clk) disable iff (rst || !armed)
        (redirect_valid && upd_ena) |=> (rd_sel != CP0_STATUS || rd_data[STATUS_EXL]))
    else begin
        $error("Status.EXL clear on the cycle after an exception entry");
        violations++;
    end

endmodule

`default_nettype wire

// File: logic/exc_unit_top.sv
`default_nettype none

module exc_unit_top #(
    parameter int N_SLOTS = 2
) (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire  except_pkg::commit_slot_t [N_SLOTS-1:0] commit_in,
    input  wire  [mips_types_pkg::N_INT-1:0]          int_lines,
    input  wire  mips_types_pkg::cp0_sel_t            rd_sel,
    output logic                                      redirect_valid,
    output mips_types_pkg::addr_t                     redirect_pc,
    output logic                                      flush,
    output mips_types_pkg::addr_t                     rd_data
);

    import mips_types_pkg::*;
    import except_pkg::*;

    commit_slot_t [N_SLOTS-1:0] commit_q;
    slot_exc_t    [N_SLOTS-1:0] exc_q;
    cp0_update_t                cp0_upd;
    logic                       int_pending;
    addr_t                      epc_q;

    commit_stage_reg #(
        .N_SLOTS   (N_SLOTS)
    ) u_commit_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .commit_in (commit_in),
        .commit_q  (commit_q)
    );

    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        slot_exc_classify u_classify (
            .slot (commit_q[i]),
            .exc  (exc_q[i])
        );
    end

    exception_ctrl #(
        .N_SLOTS        (N_SLOTS)
    ) u_ctrl (
        .commit_q       (commit_q),
        .exc_q          (exc_q),
        .int_pending    (int_pending),
        .epc_q          (epc_q),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .cp0_upd        (cp0_upd)
    );

    cp0_regs u_cp0 (
        .clk         (clk),
        .rst         (rst),
        .cp0_upd     (cp0_upd),
        .int_lines   (int_lines),
        .int_pending (int_pending),
        .epc_q       (epc_q),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: logic/cp0_regs.sv
`default_nettype none

module cp0_regs (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire  except_pkg::cp0_update_t          cp0_upd,
    input  wire  [mips_types_pkg::N_INT-1:0]       int_lines,
    output logic                                   int_pending,
    output mips_types_pkg::addr_t                  epc_q,
    input  wire  mips_types_pkg::cp0_sel_t         rd_sel,
    output mips_types_pkg::addr_t                  rd_data
);

    import mips_types_pkg::*;

    localparam logic [7:0] STATUS_IM = 8'hff;  // Fixed without mtc0
    localparam logic       STATUS_IE = 1'b1;

    logic [N_INT-1:0] int_q;
    logic [7:0]       cause_ip;
    logic             cause_bd;
    exccode_t         cause_exccode;
    logic             status_exl;
    addr_t            epc_r;
    addr_t            badvaddr_r;
    addr_t            status_word;
    addr_t            cause_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            int_q <= '0;
        end else begin
            int_q <= int_lines;
        end
    end

    assign cause_ip = {int_q, 2'b00};  // IP1..0 stay zero without mtc0

    always_ff @(posedge clk) begin
        if (rst) begin
            status_exl    <= 1'b1;
            cause_bd      <= 1'b0;
            cause_exccode <= '0;
            epc_r         <= '0;
            badvaddr_r    <= '0;
        end else if (cp0_upd.update_ena) begin
            status_exl    <= 1'b1;
            cause_bd      <= cp0_upd.bd;
            cause_exccode <= cp0_upd.exccode;
            epc_r         <= cp0_upd.epc;
            if (cp0_upd.badvaddr_ena) begin
                badvaddr_r <= cp0_upd.badvaddr;
            end
        end else if (cp0_upd.cls_exl) begin
            status_exl    <= 1'b0;
        end
    end

    assign int_pending = STATUS_IE && !status_exl && |(cause_ip & STATUS_IM);
    assign epc_q       = epc_r;

    assign status_word = {9'd0, 1'b1, 6'd0, STATUS_IM, 6'd0, status_exl, STATUS_IE};  // BEV=1
    assign cause_word  = {cause_bd, 15'd0, cause_ip, 1'b0, cause_exccode, 2'b00};

    always_comb begin
        case (rd_sel)
            CP0_BADVADDR: rd_data = badvaddr_r;
            CP0_STATUS:   rd_data = status_word;
            CP0_CAUSE:    rd_data = cause_word;
            CP0_EPC:      rd_data = epc_r;
            default:      rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exception_ctrl.sv
`default_nettype none

module exception_ctrl #(
    parameter int N_SLOTS = 2
) (
    input  wire  except_pkg::commit_slot_t [N_SLOTS-1:0] commit_q,
    input  wire  except_pkg::slot_exc_t    [N_SLOTS-1:0] exc_q,
    input  wire                                       int_pending,
    input  wire  mips_types_pkg::addr_t               epc_q,
    output logic                                      redirect_valid,
    output mips_types_pkg::addr_t                     redirect_pc,
    output logic                                      flush,
    output except_pkg::cp0_update_t                   cp0_upd
);

    import mips_types_pkg::*;
    import except_pkg::*;

    localparam int IDX_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

    logic             win_hit;
    logic [IDX_W-1:0] win_idx;
    slot_exc_t        win_exc;
    logic             take_int;

    // Oldest slot with an exception
    always_comb begin
        win_hit = 1'b0;
        win_idx = '0;
        for (int i = 0; i < N_SLOTS; i++) begin
            if (!win_hit && commit_q[i].valid && exc_q[i].has_exc) begin
                win_hit = 1'b1;
                win_idx = IDX_W'(i);
            end
        end
    end

    assign win_exc  = exc_q[win_idx];
    assign take_int = int_pending && commit_q[0].valid;  // Interrupt rides on slot 0

    always_comb begin
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        cp0_upd        = '0;
        if (take_int) begin
            redirect_valid     = 1'b1;
            redirect_pc        = EXC_VECTOR;
            cp0_upd.update_ena = 1'b1;
            cp0_upd.exccode    = EXC_INT;
            cp0_upd.bd         = exc_q[0].bd;
            cp0_upd.epc        = exc_q[0].epc;
        end else if (win_hit) begin
            redirect_valid = 1'b1;
            if (win_exc.is_eret) begin
                redirect_pc     = epc_q;
                cp0_upd.cls_exl = 1'b1;                     // No CP0 write on return
            end else begin
                redirect_pc          = EXC_VECTOR;
                cp0_upd.update_ena   = 1'b1;
                cp0_upd.exccode      = win_exc.code;
                cp0_upd.bd           = win_exc.bd;
                cp0_upd.epc          = win_exc.epc;
                cp0_upd.badvaddr_ena = win_exc.badvaddr_ena;
                cp0_upd.badvaddr     = win_exc.badvaddr;
            end
        end
    end

    assign flush = redirect_valid;

endmodule

`default_nettype wire

// File: logic/slot_exc_classify.sv
`default_nettype none

module slot_exc_classify (
    input  wire  except_pkg::commit_slot_t slot,
    output except_pkg::slot_exc_t          exc
);

    import mips_types_pkg::*;
    import except_pkg::*;

    exc_flags_t flags_v;

    assign flags_v = slot.valid ? slot.flags : '0;  // Empty slot raises nothing

    always_comb begin
        exc              = '0;
        exc.has_exc      = |flags_v;
        exc.bd           = slot.in_delay_slot;
        exc.epc          = slot.in_delay_slot ? slot.pc - 32'd4 : slot.pc;  // Point at the branch

        // Fixed priority, fetch fault first
        if (flags_v.inst_adel) begin
            exc.code         = EXC_ADEL;
            exc.badvaddr_ena = 1'b1;
            exc.badvaddr     = slot.pc;
        end else if (flags_v.ri) begin
            exc.code         = EXC_RI;
        end else if (flags_v.overflow) begin
            exc.code         = EXC_OV;
        end else if (flags_v.syscall) begin
            exc.code         = EXC_SYS;
        end else if (flags_v.brk) begin
            exc.code         = EXC_BP;
        end else if (flags_v.eret) begin
            exc.is_eret      = 1'b1;
        end else if (flags_v.data_adel) begin
            exc.code         = EXC_ADEL;
            exc.badvaddr_ena = 1'b1;
            exc.badvaddr     = slot.data_addr;
        end else if (flags_v.data_ades) begin
            exc.code         = EXC_ADES;
            exc.badvaddr_ena = 1'b1;
            exc.badvaddr     = slot.data_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/commit_stage_reg.sv
`default_nettype none

module commit_stage_reg #(
    parameter int N_SLOTS = 2
) (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire                                       flush,
    input  wire  except_pkg::commit_slot_t [N_SLOTS-1:0] commit_in,
    output except_pkg::commit_slot_t       [N_SLOTS-1:0] commit_q
);

    import except_pkg::*;

    commit_slot_t [N_SLOTS-1:0] stage_q;

    // Only the valid bits are control state, payload just follows the input
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_SLOTS; i++) begin
            if (rst || flush) begin
                stage_q[i].valid <= 1'b0;           // Kill whatever arrives with the flush edge
            end else begin
                stage_q[i].valid <= commit_in[i].valid;
            end
            stage_q[i].pc            <= commit_in[i].pc;
            stage_q[i].in_delay_slot <= commit_in[i].in_delay_slot;
            stage_q[i].data_addr     <= commit_in[i].data_addr;
            stage_q[i].flags         <= commit_in[i].flags;
        end
    end

    assign commit_q = stage_q;

endmodule

`default_nettype wire

// File: logic/except_pkg.sv
`default_nettype none

package except_pkg;

    typedef struct packed {
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic data_adel;
        logic data_ades;
        logic overflow;
        logic ri;
    } exc_flags_t;

    // One instruction slot of the commit bundle
    typedef struct packed {
        logic                  valid;
        mips_types_pkg::addr_t pc;
        logic                  in_delay_slot;
        mips_types_pkg::addr_t data_addr;
        exc_flags_t            flags;
    } commit_slot_t;

    typedef struct packed {
        logic                     has_exc;
        logic                     is_eret;
        mips_types_pkg::exccode_t code;
        logic                     bd;
        mips_types_pkg::addr_t    epc;
        logic                     badvaddr_ena;
        mips_types_pkg::addr_t    badvaddr;
    } slot_exc_t;

    typedef struct packed {
        logic                     update_ena;
        mips_types_pkg::exccode_t exccode;
        logic                     bd;
        mips_types_pkg::addr_t    epc;
        logic                     badvaddr_ena;
        mips_types_pkg::addr_t    badvaddr;
        logic                     cls_exl;    // Eret returns, clear Status.EXL
    } cp0_update_t;

endpackage

`default_nettype wire

// File: logic/mips_types_pkg.sv
`default_nettype none

package mips_types_pkg;

    typedef logic [31:0] addr_t;        // Address or data word
    typedef logic [4:0]  exccode_t;     // Cause.ExcCode
    typedef logic [4:0]  cp0_sel_t;     // mfc0 register number

    // Exception codes as written to Cause.ExcCode
    localparam exccode_t EXC_INT  = 5'h00;
    localparam exccode_t EXC_ADEL = 5'h04;
    localparam exccode_t EXC_ADES = 5'h05;
    localparam exccode_t EXC_SYS  = 5'h08;
    localparam exccode_t EXC_BP   = 5'h09;
    localparam exccode_t EXC_RI   = 5'h0a;
    localparam exccode_t EXC_OV   = 5'h0c;

    localparam addr_t EXC_VECTOR = 32'hbfc0_0380;  // General vector with BEV=1

    localparam cp0_sel_t CP0_BADVADDR = 5'd8;
    localparam cp0_sel_t CP0_STATUS   = 5'd12;
    localparam cp0_sel_t CP0_CAUSE    = 5'd13;
    localparam cp0_sel_t CP0_EPC      = 5'd14;

    localparam int N_INT = 6;           // Hardware interrupt lines

endpackage

`default_nettype wire
